// ==== hdl/rv32_mem_pkg.sv ====
package rv32_mem_pkg;

    // Access type, stores reuse LB/LH/LW as SB/SH/SW
    localparam logic [2:0] LOAD_LB   = 3'd0;
    localparam logic [2:0] LOAD_LH   = 3'd1;
    localparam logic [2:0] LOAD_LW   = 3'd2;
    localparam logic [2:0] LOAD_LBU  = 3'd3;
    localparam logic [2:0] LOAD_LHU  = 3'd4;
    localparam logic [2:0] LOAD_NONE = 3'd7;

    // Writeback source select
    localparam logic [2:0] W_SEL_DLOAD = 3'd0;
    localparam logic [2:0] W_SEL_PC    = 3'd1;
    localparam logic [2:0] W_SEL_IMM_U = 3'd2;
    localparam logic [2:0] W_SEL_ALU   = 3'd3;
    localparam logic [2:0] W_SEL_PRIV  = 3'd4;

    // Data RAM size in 32-bit words
    localparam int DMEM_WORDS = 256;

    // Word index width into the data RAM
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

endpackage

// ==== hdl/data_bus_if.sv ====
interface data_bus_if;

    // Request side
    logic        ren;
    logic        wen;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  byte_en;

    // Response side
    logic [31:0] rdata;
    logic        busy;
    logic        error;

    modport cpu (
        output ren,
        output wen,
        output addr,
        output wdata,
        output byte_en,
        input  rdata,
        input  busy,
        input  error
    );

    modport mem (
        input  ren,
        input  wen,
        input  addr,
        input  wdata,
        input  byte_en,
        output rdata,
        output busy,
        output error
    );

endinterface

// ==== hdl/dmem_extender.sv ====
module dmem_extender (
    input  logic [31:0] dmem_in,
    input  logic [2:0]  load_type,
    input  logic [3:0]  byte_en,
    output logic [31:0] ext_out
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // Pull the enabled lane down to bit 0
    always_comb begin
        case (byte_en)
            4'b0010: lane_byte = dmem_in[15:8];
            4'b0100: lane_byte = dmem_in[23:16];
            4'b1000: lane_byte = dmem_in[31:24];
            default: lane_byte = dmem_in[7:0];
        endcase

        // Half-word enables are only 0011 or 1100
        if (byte_en[3]) begin
            lane_half = dmem_in[31:16];
        end else begin
            lane_half = dmem_in[15:0];
        end
    end

    always_comb begin
        case (load_type)
            rv32_mem_pkg::LOAD_LB: begin
                ext_out = {{24{lane_byte[7]}}, lane_byte};
            end
            rv32_mem_pkg::LOAD_LBU: begin
                ext_out = {24'h000000, lane_byte};
            end
            rv32_mem_pkg::LOAD_LH: begin
                ext_out = {{16{lane_half[15]}}, lane_half};
            end
            rv32_mem_pkg::LOAD_LHU: begin
                ext_out = {16'h0000, lane_half};
            end
            rv32_mem_pkg::LOAD_LW: begin
                ext_out = dmem_in;
            end
            default: ext_out = '0;
        endcase
    end

endmodule

// ==== hdl/fence_tracker.sv ====
module fence_tracker (
    input  logic CLK,
    input  logic nRST,
    input  logic req,
    input  logic done_a,
    input  logic done_b,
    output logic pulse,
    output logic stall
);

    logic req_reg;
    logic flag_a;
    logic flag_b;
    logic flag_a_next;
    logic flag_b_next;

    // Rising edge of the request level
    assign pulse = req & ~req_reg;

    // Sticky completion flags, a done input wins over the clearing pulse
    always_comb begin
        flag_a_next = flag_a;
        flag_b_next = flag_b;
        if (pulse) begin
            flag_a_next = 1'b0;
            flag_b_next = 1'b0;
        end
        if (done_a) begin
            flag_a_next = 1'b1;
        end
        if (done_b) begin
            flag_b_next = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_reg <= 1'b0;
            flag_a  <= 1'b1;
            flag_b  <= 1'b1;
        end else begin
            req_reg <= req;
            flag_a  <= flag_a_next;
            flag_b  <= flag_b_next;
        end
    end

    // Hold the pipeline until both sides report done
    assign stall = req_reg & ~(flag_a & flag_b);

endmodule

// ==== hdl/data_ram.sv ====
module data_ram (
    input logic     CLK,
    input logic     nRST,
    data_bus_if.mem dbus
);

    logic [31:0] mem [rv32_mem_pkg::DMEM_WORDS];

    logic                                req;
    logic                                seen;
    logic                                taken;
    logic                                in_range;
    logic                                commit;
    logic [rv32_mem_pkg::DMEM_IDX_W-1:0] idx;

    assign req = dbus.ren | dbus.wen;

    // Word index, byte offset bits dropped
    assign idx = dbus.addr[rv32_mem_pkg::DMEM_IDX_W+1:2];

    // Anything above the top word is out of range
    assign in_range = (dbus.addr[31:rv32_mem_pkg::DMEM_IDX_W+2] == '0);

    // seen gives the single busy cycle
    // taken keeps a held request from writing twice
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            seen  <= 1'b0;
            taken <= 1'b0;
        end else begin
            seen  <= req;
            taken <= req & seen;
        end
    end

    assign dbus.busy  = req & ~seen;
    assign dbus.error = req & seen & ~in_range;
    assign dbus.rdata = mem[idx];

    // Commit at the closing edge of the first non-busy cycle
    assign commit = dbus.wen & seen & ~taken & in_range;

    always_ff @(posedge CLK) begin
        if (commit) begin
            for (int i = 0; i < 4; i++) begin
                if (dbus.byte_en[i]) begin
                    mem[idx][8*i +: 8] <= dbus.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/mem_stage.sv ====
module mem_stage (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        dren,
    input  logic        dwen,
    input  logic [2:0]  load_type,
    input  logic [31:0] port_out,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] pc4,
    input  logic [31:0] imm_u,
    input  logic [2:0]  w_sel,
    input  logic        reg_write_in,
    input  logic [4:0]  rd_in,
    input  logic        ifence,
    input  logic        sfence,
    input  logic        suppress_data,
    input  logic [31:0] csr_rdata,
    input  logic        iflush_done,
    input  logic        dflush_done,
    input  logic        itlb_fence_done,
    input  logic        dtlb_fence_done,
    data_bus_if.cpu     dbus,
    output logic [31:0] reg_wdata,
    output logic        reg_write,
    output logic [4:0]  rd,
    output logic        mal_load,
    output logic        mal_store,
    output logic        fault_load,
    output logic        fault_store,
    output logic        mem_busy,
    output logic        cache_flush,
    output logic        tlb_fence,
    output logic        fence_stall,
    output logic [8:0]  fence_asid,
    output logic [31:0] fence_va
);

    logic [3:0]  byte_en;
    logic [31:0] dload_ext;
    logic        mal_addr;
    logic        cache_stall;
    logic        tlb_stall;

    // Alignment by access size
    always_comb begin
        case (load_type)
            rv32_mem_pkg::LOAD_LW: mal_addr = (port_out[1:0] != 2'b00);
            rv32_mem_pkg::LOAD_LH,
            rv32_mem_pkg::LOAD_LHU: mal_addr = port_out[0];
            default: mal_addr = 1'b0;
        endcase
    end

    // Lane enables from size and low address bits
    always_comb begin
        case (load_type)
            rv32_mem_pkg::LOAD_LB,
            rv32_mem_pkg::LOAD_LBU: byte_en = 4'b0001 << port_out[1:0];
            rv32_mem_pkg::LOAD_LH,
            rv32_mem_pkg::LOAD_LHU: begin
                case (port_out[1:0])
                    2'b00:   byte_en = 4'b0011;
                    2'b10:   byte_en = 4'b1100;
                    default: byte_en = 4'b0000;
                endcase
            end
            rv32_mem_pkg::LOAD_LW: byte_en = 4'b1111;
            default: byte_en = 4'b0000;
        endcase
    end

    // Store data copied into every lane, byte_en picks the right one
    always_comb begin
        case (load_type)
            rv32_mem_pkg::LOAD_LB: dbus.wdata = {4{rs2_data[7:0]}};
            rv32_mem_pkg::LOAD_LH: dbus.wdata = {2{rs2_data[15:0]}};
            rv32_mem_pkg::LOAD_LW: dbus.wdata = rs2_data;
            default: dbus.wdata = '0;
        endcase
    end

    // Misaligned or suppressed accesses never reach the bus
    assign dbus.ren     = dren & ~suppress_data & ~mal_addr;
    assign dbus.wen     = dwen & ~suppress_data & ~mal_addr;
    assign dbus.addr    = port_out;
    assign dbus.byte_en = byte_en;

    dmem_extender dmem_ext_i (
        .dmem_in   (dbus.rdata),
        .load_type (load_type),
        .byte_en   (byte_en),
        .ext_out   (dload_ext)
    );

    assign mal_load    = dren & mal_addr;
    assign mal_store   = dwen & mal_addr;
    assign fault_load  = dren & dbus.error;
    assign fault_store = dwen & dbus.error;
    assign mem_busy    = dbus.busy;

    // Writeback
    always_comb begin
        case (w_sel)
            rv32_mem_pkg::W_SEL_DLOAD: reg_wdata = dload_ext;
            rv32_mem_pkg::W_SEL_PC:    reg_wdata = pc4;
            rv32_mem_pkg::W_SEL_IMM_U: reg_wdata = imm_u;
            rv32_mem_pkg::W_SEL_ALU:   reg_wdata = port_out;
            rv32_mem_pkg::W_SEL_PRIV:  reg_wdata = csr_rdata;
            default: reg_wdata = '0;
        endcase
    end

    assign reg_write = reg_write_in & ~suppress_data;
    assign rd        = rd_in;

    // Cache flush on fence.i
    fence_tracker cache_fence_i (
        .CLK    (CLK),
        .nRST   (nRST),
        .req    (ifence),
        .done_a (iflush_done),
        .done_b (dflush_done),
        .pulse  (cache_flush),
        .stall  (cache_stall)
    );

    // TLB shootdown on sfence.vma
    fence_tracker tlb_fence_i (
        .CLK    (CLK),
        .nRST   (nRST),
        .req    (sfence),
        .done_a (itlb_fence_done),
        .done_b (dtlb_fence_done),
        .pulse  (tlb_fence),
        .stall  (tlb_stall)
    );

    assign fence_stall = cache_stall | tlb_stall;
    assign fence_asid  = rs2_data[8:0];
    assign fence_va    = rs1_data;

endmodule

// ==== hdl/mem_stage_top.sv ====
module mem_stage_top (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        dren,
    input  logic        dwen,
    input  logic [2:0]  load_type,
    input  logic [31:0] port_out,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic [31:0] pc4,
    input  logic [31:0] imm_u,
    input  logic [2:0]  w_sel,
    input  logic        reg_write_in,
    input  logic [4:0]  rd_in,
    input  logic        ifence,
    input  logic        sfence,
    input  logic        suppress_data,
    input  logic [31:0] csr_rdata,
    input  logic        iflush_done,
    input  logic        dflush_done,
    input  logic        itlb_fence_done,
    input  logic        dtlb_fence_done,
    output logic [31:0] reg_wdata,
    output logic        reg_write,
    output logic [4:0]  rd,
    output logic        mal_load,
    output logic        mal_store,
    output logic        fault_load,
    output logic        fault_store,
    output logic        mem_busy,
    output logic        cache_flush,
    output logic        tlb_fence,
    output logic        fence_stall,
    output logic [8:0]  fence_asid,
    output logic [31:0] fence_va
);

    // Stage to RAM data bus
    data_bus_if dbus ();

    mem_stage stage_i (
        .CLK             (CLK),
        .nRST            (nRST),
        .dren            (dren),
        .dwen            (dwen),
        .load_type       (load_type),
        .port_out        (port_out),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .pc4             (pc4),
        .imm_u           (imm_u),
        .w_sel           (w_sel),
        .reg_write_in    (reg_write_in),
        .rd_in           (rd_in),
        .ifence          (ifence),
        .sfence          (sfence),
        .suppress_data   (suppress_data),
        .csr_rdata       (csr_rdata),
        .iflush_done     (iflush_done),
        .dflush_done     (dflush_done),
        .itlb_fence_done (itlb_fence_done),
        .dtlb_fence_done (dtlb_fence_done),
        .dbus            (dbus.cpu),
        .reg_wdata       (reg_wdata),
        .reg_write       (reg_write),
        .rd              (rd),
        .mal_load        (mal_load),
        .mal_store       (mal_store),
        .fault_load      (fault_load),
        .fault_store     (fault_store),
        .mem_busy        (mem_busy),
        .cache_flush     (cache_flush),
        .tlb_fence       (tlb_fence),
        .fence_stall     (fence_stall),
        .fence_asid      (fence_asid),
        .fence_va        (fence_va)
    );

    data_ram ram_i (
        .CLK  (CLK),
        .nRST (nRST),
        .dbus (dbus.mem)
    );

endmodule

// ==== sim/mem_stage_assertions.sv ====
module mem_stage_assertions (
    input logic        CLK,
    input logic        nRST,
    input logic        ren,
    input logic        wen,
    input logic [31:0] addr,
    input logic [2:0]  load_type,
    input logic        mem_busy,
    input logic        cache_flush,
    input logic        tlb_fence,
    input logic        fence_stall
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    logic [1:0] align_mask;

    // Low address bits that must be zero for the access size
    assign align_mask = (load_type == rv32_mem_pkg::LOAD_LW) ? 2'b11 :
                        (load_type == rv32_mem_pkg::LOAD_LH ||
                         load_type == rv32_mem_pkg::LOAD_LHU) ? 2'b01 : 2'b00;

    // Fence requests become single-cycle pulses
    cache_flush_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        cache_flush |=> !cache_flush)
        else begin
            $error("cache_flush high for more than one cycle");
            fail_count++;
        end

    tlb_fence_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        tlb_fence |=> !tlb_fence)
        else begin
            $error("tlb_fence high for more than one cycle");
            fail_count++;
        end

    read_write_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(ren && wen))
        else begin
            $error("ren and wen both high");
            fail_count++;
        end

    // A misaligned access must stay off the bus
    no_misaligned_request: assert property (@(posedge CLK) disable iff (!nRST)
        (ren || wen) |-> (addr[1:0] & align_mask) == 2'b00)
        else begin
            $error("bus request issued for a misaligned access");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge CLK)
        !nRST |-> !mem_busy && !fence_stall && !cache_flush && !tlb_fence)
        else begin
            $error("busy, stall or fence pulse active in reset");
            fail_count++;
        end

endmodule

bind mem_stage mem_stage_assertions checks_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .ren         (dbus.ren),
    .wen         (dbus.wen),
    .addr        (dbus.addr),
    .load_type   (load_type),
    .mem_busy    (mem_busy),
    .cache_flush (cache_flush),
    .tlb_fence   (tlb_fence),
    .fence_stall (fence_stall)
);

// ==== sim/tb_mem_stage.sv ====
module tb_mem_stage;

    timeunit 1ns;
    timeprecision 100ps;

    // The tests take about 450 cycles
    localparam int MAX_CYCLES = 2000;
    localparam int RAM_BYTES  = 4 * rv32_mem_pkg::DMEM_WORDS;
    localparam int BUSY_LIMIT = 8;

    logic        CLK, nRST;
    logic        dren, dwen, reg_write_in, ifence, sfence, suppress_data;
    logic        iflush_done, dflush_done, itlb_fence_done, dtlb_fence_done;
    logic [2:0]  load_type, w_sel;
    logic [4:0]  rd_in, rd;
    logic [31:0] port_out, rs1_data, rs2_data, pc4, imm_u, csr_rdata, reg_wdata, fence_va;
    logic        reg_write, mal_load, mal_store, fault_load, fault_store, mem_busy;
    logic        cache_flush, tlb_fence, fence_stall;
    logic [8:0]  fence_asid;

    // Byte-wide picture of what the data RAM should hold
    logic [7:0]  ref_mem [RAM_BYTES];

    // Outputs captured in the non-busy cycle of the last access
    logic [31:0] got_wdata;
    logic [4:0]  got_rd;
    logic [4:0]  sent_rd;
    logic        got_write, got_mal_load, got_mal_store, got_fault_load, got_fault_store;

    int error_count = 0;
    int cycle_count = 0;

    mem_stage_top dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("error %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic drive_idle();
        dren = 1'b0;
        dwen = 1'b0;
        load_type = rv32_mem_pkg::LOAD_NONE;
        w_sel = rv32_mem_pkg::W_SEL_DLOAD;
        port_out = '0;
        rs1_data = '0;
        rs2_data = '0;
        pc4 = '0;
        imm_u = '0;
        csr_rdata = '0;
        reg_write_in = 1'b0;
        rd_in = '0;
        suppress_data = 1'b0;
        ifence = 1'b0;
        sfence = 1'b0;
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        itlb_fence_done = 1'b0;
        dtlb_fence_done = 1'b0;
    endtask

    // Alignment rule per access size
    function automatic logic aligned(input logic [2:0] ltype, input logic [31:0] addr);
        case (ltype)
            rv32_mem_pkg::LOAD_LW: return addr[1:0] == 2'b00;
            rv32_mem_pkg::LOAD_LH, rv32_mem_pkg::LOAD_LHU: return addr[0] == 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    // Little-endian load from the byte model
    function automatic logic [31:0] expected_load(input logic [2:0] ltype,
                                                  input logic [31:0] addr);
        int a;
        a = int'(addr);
        case (ltype)
            rv32_mem_pkg::LOAD_LB: return {{24{ref_mem[a][7]}}, ref_mem[a]};
            rv32_mem_pkg::LOAD_LBU: return {24'h000000, ref_mem[a]};
            rv32_mem_pkg::LOAD_LH: return {{16{ref_mem[a + 1][7]}}, ref_mem[a + 1], ref_mem[a]};
            rv32_mem_pkg::LOAD_LHU: return {16'h0000, ref_mem[a + 1], ref_mem[a]};
            default: return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
        endcase
    endfunction

    task automatic model_store(input logic [2:0] ltype, input logic [31:0] addr,
                               input logic [31:0] data);
        int nbytes;
        case (ltype)
            rv32_mem_pkg::LOAD_LB: nbytes = 1;
            rv32_mem_pkg::LOAD_LH: nbytes = 2;
            default: nbytes = 4;
        endcase
        for (int i = 0; i < nbytes; i++) begin
            ref_mem[int'(addr) + i] = data[8*i +: 8];
        end
    endtask

    // One request held until busy drops, then one more edge for the write
    task automatic mem_access(input logic is_load, input logic [2:0] ltype,
                              input logic [31:0] addr, input logic [31:0] data,
                              input logic supp);
        int waited;
        @(negedge CLK);
        dren = is_load;
        dwen = ~is_load;
        load_type = ltype;
        port_out = addr;
        rs2_data = data;
        w_sel = rv32_mem_pkg::W_SEL_DLOAD;
        reg_write_in = is_load;
        rd_in = 5'($urandom_range(31, 1));
        suppress_data = supp;
        sent_rd = rd_in;
        waited = 0;
        #10;
        // Only a request that reaches the bus sees the busy cycle
        check_bit("mem_busy in first cycle", mem_busy, aligned(ltype, addr) & ~supp);
        @(negedge CLK);
        while (mem_busy && waited < BUSY_LIMIT) begin
            @(negedge CLK);
            waited++;
        end
        if (mem_busy) begin
            error_count++;
            $display("access to %h still busy after %0d cycles", addr, BUSY_LIMIT);
        end else begin
            check_value("extra busy cycles", 32'(waited), 32'd0);
        end
        got_wdata = reg_wdata;
        got_write = reg_write;
        got_rd = rd;
        got_mal_load = mal_load;
        got_mal_store = mal_store;
        got_fault_load = fault_load;
        got_fault_store = fault_store;
        @(negedge CLK);
        drive_idle();
    endtask

    // Checks the four flags; a store that lands also updates the model
    task automatic flagged_access(input logic is_load, input logic [2:0] ltype,
                                  input logic [31:0] addr, input logic [31:0] data);
        logic ok_align;
        logic ok_range;
        ok_align = aligned(ltype, addr);
        ok_range = addr < 32'(RAM_BYTES);
        mem_access(is_load, ltype, addr, data, 1'b0);
        check_bit("mal_load", got_mal_load, is_load & ~ok_align);
        check_bit("mal_store", got_mal_store, ~is_load & ~ok_align);
        check_bit("fault_load", got_fault_load, is_load & ok_align & ~ok_range);
        check_bit("fault_store", got_fault_store, ~is_load & ok_align & ~ok_range);
        if (!is_load && ok_align && ok_range) begin
            model_store(ltype, addr, data);
        end
    endtask

    task automatic load_check(input logic [2:0] ltype, input logic [31:0] addr);
        flagged_access(1'b1, ltype, addr, '0);
        check_value("load data", got_wdata, expected_load(ltype, addr));
        check_bit("reg_write on load", got_write, 1'b1);
        check_value("rd", 32'(got_rd), 32'(sent_rd));
    endtask

    task automatic store_load_words();
        logic [31:0] addrs [6];
        addrs[0] = 32'h000;
        addrs[1] = 32'h004;
        addrs[2] = 32'h080;
        addrs[3] = 32'h100;
        addrs[4] = 32'h200;
        addrs[5] = 32'h3FC;
        for (int i = 0; i < 6; i++) begin
            flagged_access(1'b0, rv32_mem_pkg::LOAD_LW, addrs[i], $urandom());
            load_check(rv32_mem_pkg::LOAD_LW, addrs[i]);
        end
    endtask

    task automatic read_all_lanes(input logic [31:0] base);
        load_check(rv32_mem_pkg::LOAD_LW, base);
        for (int off = 0; off < 4; off++) begin
            load_check(rv32_mem_pkg::LOAD_LB, base + 32'(off));
            load_check(rv32_mem_pkg::LOAD_LBU, base + 32'(off));
        end
        for (int off = 0; off < 4; off += 2) begin
            load_check(rv32_mem_pkg::LOAD_LH, base + 32'(off));
            load_check(rv32_mem_pkg::LOAD_LHU, base + 32'(off));
        end
    endtask

    task automatic sub_word_access();
        logic [31:0] base;
        logic [31:0] data;
        base = 32'h040;
        flagged_access(1'b0, rv32_mem_pkg::LOAD_LW, base, $urandom());
        for (int off = 0; off < 4; off++) begin
            data = $urandom();
            // Mix of negative and positive bytes for sign extension
            data[7] = off[0];
            flagged_access(1'b0, rv32_mem_pkg::LOAD_LB, base + 32'(off), data);
            read_all_lanes(base);
        end
        for (int off = 0; off < 4; off += 2) begin
            data = $urandom();
            data[15] = (off == 0);
            flagged_access(1'b0, rv32_mem_pkg::LOAD_LH, base + 32'(off), data);
            read_all_lanes(base);
        end
    endtask

    task automatic misaligned_access();
        logic [31:0] base;
        base = 32'h080;
        for (int off = 1; off < 4; off++) begin
            flagged_access(1'b1, rv32_mem_pkg::LOAD_LW, base + 32'(off), '0);
            flagged_access(1'b0, rv32_mem_pkg::LOAD_LW, base + 32'(off), $urandom());
            if (off != 2) begin
                flagged_access(1'b1, rv32_mem_pkg::LOAD_LH, base + 32'(off), '0);
                flagged_access(1'b1, rv32_mem_pkg::LOAD_LHU, base + 32'(off), '0);
                flagged_access(1'b0, rv32_mem_pkg::LOAD_LH, base + 32'(off), $urandom());
            end
        end
        load_check(rv32_mem_pkg::LOAD_LW, base);
    endtask

    task automatic out_of_range_access();
        logic [31:0] addrs [4];
        addrs[0] = 32'(RAM_BYTES);
        addrs[1] = 32'(RAM_BYTES + 4);
        addrs[2] = 32'h0000_1000;
        addrs[3] = 32'hFFFF_FFFC;
        for (int i = 0; i < 4; i++) begin
            flagged_access(1'b0, rv32_mem_pkg::LOAD_LW, addrs[i], $urandom());
            flagged_access(1'b1, rv32_mem_pkg::LOAD_LW, addrs[i], '0);
        end
        // Words that the low address bits of those accesses point at
        load_check(rv32_mem_pkg::LOAD_LW, 32'h000);
        load_check(rv32_mem_pkg::LOAD_LW, 32'h004);
        load_check(rv32_mem_pkg::LOAD_LW, 32'h3FC);
    endtask

    task automatic set_fence(input logic use_tlb, input logic level, input logic a,
                             input logic b);
        if (use_tlb) begin
            sfence = level;
            itlb_fence_done = a;
            dtlb_fence_done = b;
        end else begin
            ifence = level;
            iflush_done = a;
            dflush_done = b;
        end
    endtask

    // order 0 gives done_a first, 1 gives done_b first, 2 gives both together
    task automatic fence_sequence(input logic use_tlb, input int order);
        @(negedge CLK);
        set_fence(use_tlb, 1'b1, 1'b0, 1'b0);
        rs1_data = $urandom();
        rs2_data = $urandom();
        #10;
        check_bit("fence pulse", use_tlb ? tlb_fence : cache_flush, 1'b1);
        check_bit("other fence pulse", use_tlb ? cache_flush : tlb_fence, 1'b0);
        check_bit("fence_stall in pulse cycle", fence_stall, 1'b0);
        // Virtual address from rs1, ASID from the low bits of rs2
        check_value("fence_va", fence_va, rs1_data);
        check_value("fence_asid", 32'(fence_asid), 32'(rs2_data[8:0]));
        repeat (3) begin
            @(negedge CLK);
            check_bit("fence pulse while held", use_tlb ? tlb_fence : cache_flush, 1'b0);
            check_bit("fence_stall while waiting", fence_stall, 1'b1);
        end
        set_fence(use_tlb, 1'b1, order != 1, order != 0);
        @(negedge CLK);
        set_fence(use_tlb, 1'b1, 1'b0, 1'b0);
        if (order != 2) begin
            check_bit("fence_stall after one done", fence_stall, 1'b1);
            set_fence(use_tlb, 1'b1, order == 1, order == 0);
            @(negedge CLK);
            set_fence(use_tlb, 1'b1, 1'b0, 1'b0);
        end
        check_bit("fence_stall after both done", fence_stall, 1'b0);
        check_bit("fence pulse after done", use_tlb ? tlb_fence : cache_flush, 1'b0);
        set_fence(use_tlb, 1'b0, 1'b0, 1'b0);
        @(negedge CLK);
        check_bit("fence_stall after release", fence_stall, 1'b0);
    endtask

    task automatic writeback_select();
        logic [31:0] expected;
        for (int i = 0; i < 4; i++) begin
            @(negedge CLK);
            pc4 = $urandom();
            imm_u = $urandom();
            port_out = $urandom();
            csr_rdata = $urandom();
            reg_write_in = 1'b1;
            case (i)
                0: begin
                    w_sel = rv32_mem_pkg::W_SEL_PC;
                    expected = pc4;
                end
                1: begin
                    w_sel = rv32_mem_pkg::W_SEL_IMM_U;
                    expected = imm_u;
                end
                2: begin
                    w_sel = rv32_mem_pkg::W_SEL_ALU;
                    expected = port_out;
                end
                default: begin
                    w_sel = rv32_mem_pkg::W_SEL_PRIV;
                    expected = csr_rdata;
                end
            endcase
            @(negedge CLK);
            check_value("reg_wdata", reg_wdata, expected);
            check_bit("reg_write", reg_write, 1'b1);
        end
        suppress_data = 1'b1;
        @(negedge CLK);
        check_bit("reg_write under suppress", reg_write, 1'b0);
        drive_idle();
        // A suppressed store leaves the model untouched
        mem_access(1'b0, rv32_mem_pkg::LOAD_LW, 32'h080, $urandom(), 1'b1);
        check_bit("fault_store on suppressed store", got_fault_store, 1'b0);
        load_check(rv32_mem_pkg::LOAD_LW, 32'h080);
    endtask

    initial begin
        int assert_fails;
        void'($urandom(16));
        drive_idle();
        nRST = 1'b0;
        repeat (10) @(negedge CLK);
        nRST = 1'b1;
        store_load_words();
        sub_word_access();
        misaligned_access();
        out_of_range_access();
        for (int order = 0; order < 3; order++) begin
            fence_sequence(1'b0, order);
            fence_sequence(1'b1, order);
        end
        writeback_select();
        repeat (2) @(negedge CLK);
        assert_fails = dut_i.stage_i.checks_i.fail_count;
        $display("%0d check errors, %0d assertion failures", error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/rv32_mem_pkg.sv
hdl/data_bus_if.sv
hdl/dmem_extender.sv
hdl/fence_tracker.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/mem_stage_top.sv
sim/mem_stage_assertions.sv
sim/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_mem_stage -Mdir "$OBJ" -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Let assertion failures be counted instead of stopping at the first one
"./$OBJ/Vtb_mem_stage" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1
